//--- logic/hamming_code_pkg.sv
/* Hamming(7,4) code definitions shared by the encoder and decoder.
   Holds the widths, the codeword layout and the syndrome values for each data bit. */
package hamming_code_pkg;

    localparam int data_bits   = 4;
    localparam int parity_bits = 3;
    localparam int code_bits   = data_bits + parity_bits;

    // one 7-bit word, seen either as bits or as parity/data fields
    typedef union packed {
        logic [code_bits-1:0] raw;
        struct packed {
            logic [parity_bits-1:0] parity;
            logic [data_bits-1:0]   data;
        } f;
    } codeword_u;

    // syndrome pointing at each data bit, ordered {p2, p1, p0}
    localparam logic [parity_bits-1:0] syn_d0 = 3'b110;
    localparam logic [parity_bits-1:0] syn_d1 = 3'b101;
    localparam logic [parity_bits-1:0] syn_d2 = 3'b011;
    localparam logic [parity_bits-1:0] syn_d3 = 3'b111;

    // parity bits over a data nibble
    function automatic logic [parity_bits-1:0] calc_parity(
        input logic [data_bits-1:0] d
    );
        logic [parity_bits-1:0] p;
        p[0] = d[1] ^ d[2] ^ d[3];
        p[1] = d[0] ^ d[2] ^ d[3];
        p[2] = d[0] ^ d[1] ^ d[3];
        return p;
    endfunction

endpackage

//--- logic/hamming_link_top.sv
/* Top level of the Hamming(7,4) serial link with plain ports.
   The channel from code_word back to rx_word is closed outside this block. */
`timescale 1ns/10ps

module hamming_link_top (
    input  logic                                   clk,
    input  logic                                   rst_n,

    // transmit side
    input  logic                                   sin,
    input  logic                                   sin_strobe,
    output logic [hamming_code_pkg::code_bits-1:0]   code_word,
    output logic                                   code_strobe,

    // receive side
    input  logic [hamming_code_pkg::code_bits-1:0]   rx_word,
    input  logic                                   rx_strobe,
    output logic [hamming_code_pkg::data_bits-1:0]   data_out,
    output logic [hamming_code_pkg::parity_bits-1:0] syndrome,
    output logic                                   corrected,
    output logic                                   data_strobe
);

    hamming_serial_encoder u_encoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .sin         (sin),
        .sin_strobe  (sin_strobe),
        .code_word   (code_word),
        .code_strobe (code_strobe)
    );

    // no link between the two halves here
    hamming_syndrome_decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_word     (rx_word),
        .rx_strobe   (rx_strobe),
        .data_out    (data_out),
        .syndrome    (syndrome),
        .corrected   (corrected),
        .data_strobe (data_strobe)
    );

endmodule

//--- logic/hamming_serial_encoder.sv
/* Transmit side: collects strobed serial bits into a nibble and emits a Hamming(7,4)
   codeword with a one-cycle strobe once every four bits. */
`timescale 1ns/10ps

module hamming_serial_encoder (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 sin,
    input  logic                                 sin_strobe,
    output logic [hamming_code_pkg::code_bits-1:0] code_word,
    output logic                                 code_strobe
);

    // first three bits of the frame, d3 ends up at the top
    logic [hamming_code_pkg::data_bits-2:0] shift_q;

    // position of the next bit inside the frame
    logic [serial_frame_pkg::bit_cnt_w-1:0] bit_cnt;

    // nibble as it stands once the current bit is added
    logic [hamming_code_pkg::data_bits-1:0] nibble;

    logic                        last_bit;
    hamming_code_pkg::codeword_u next_word;

    assign nibble   = {shift_q, sin};
    assign last_bit = sin_strobe && (bit_cnt == serial_frame_pkg::frame_last);

    // assemble the codeword from the finished nibble
    always_comb begin
        next_word.f.data   = nibble;
        next_word.f.parity = hamming_code_pkg::calc_parity(nibble);
    end

    // data shift, left into bit 0
    always_ff @(posedge clk) begin
        if (sin_strobe) begin
            shift_q <= nibble[hamming_code_pkg::data_bits-2:0];
        end
    end

    // frame counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (sin_strobe) begin
            if (last_bit) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // codeword output, held until the next frame completes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            code_word   <= '0;
            code_strobe <= 1'b0;
        end else begin
            code_strobe <= last_bit;
            if (last_bit) begin
                code_word <= next_word.raw;
            end
        end
    end

endmodule

//--- logic/hamming_syndrome_decoder.sv
/* Receive side: two-stage Hamming(7,4) decoder that corrects one flipped bit.
   Results come out two cycles after rx_strobe, and a strobe every cycle is accepted. */
`timescale 1ns/10ps

module hamming_syndrome_decoder (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [hamming_code_pkg::code_bits-1:0]   rx_word,
    input  logic                                   rx_strobe,
    output logic [hamming_code_pkg::data_bits-1:0]   data_out,
    output logic [hamming_code_pkg::parity_bits-1:0] syndrome,
    output logic                                   corrected,
    output logic                                   data_strobe
);

    hamming_code_pkg::codeword_u rx_cw;
    logic [hamming_code_pkg::parity_bits-1:0] rx_syn;

    // stage one registers
    hamming_code_pkg::codeword_u s1_word;
    logic [hamming_code_pkg::parity_bits-1:0] s1_syn;
    logic s1_valid;

    // stage two correction
    logic [2:0] err_pos;
    logic err_hit;
    hamming_code_pkg::codeword_u fixed_word;

    assign rx_cw = rx_word;

    // recomputed parity against received parity
    assign rx_syn = hamming_code_pkg::calc_parity(rx_cw.f.data) ^ rx_cw.f.parity;

    always_ff @(posedge clk) begin
        if (rx_strobe) begin
            s1_word <= rx_cw;
            s1_syn  <= rx_syn;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= rx_strobe;
        end
    end

    // syndrome to bit position
    always_comb begin
        err_hit = 1'b1;
        case (s1_syn)
            hamming_code_pkg::syn_d0: err_pos = 3'd0;
            hamming_code_pkg::syn_d1: err_pos = 3'd1;
            hamming_code_pkg::syn_d2: err_pos = 3'd2;
            hamming_code_pkg::syn_d3: err_pos = 3'd3;
            // single syndrome bit means a parity bit went bad
            3'b001: err_pos = 3'(hamming_code_pkg::data_bits);
            3'b010: err_pos = 3'(hamming_code_pkg::data_bits + 1);
            3'b100: err_pos = 3'(hamming_code_pkg::data_bits + 2);
            default: begin
                err_pos = 3'd0;
                err_hit = 1'b0;
            end
        endcase
    end

    always_comb begin
        fixed_word = s1_word;
        if (err_hit) begin
            fixed_word.raw[err_pos] = ~s1_word.raw[err_pos];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_out    <= '0;
            syndrome    <= '0;
            corrected   <= 1'b0;
            data_strobe <= 1'b0;
        end else begin
            data_strobe <= s1_valid;
            if (s1_valid) begin
                data_out  <= fixed_word.f.data;
                syndrome  <= s1_syn;
                corrected <= |s1_syn;
            end
        end
    end

endmodule

//--- logic/serial_frame_pkg.sv
/* Serial framing constants for the bit-serial transmit input.
   One frame carries one data nibble, most significant bit first. */
package serial_frame_pkg;

    // serial bits per frame, one per data bit
    localparam int frame_bits = 4;

    // width of the frame bit counter
    localparam int bit_cnt_w = 2;

    // counter value of the last bit in a frame
    localparam logic [bit_cnt_w-1:0] frame_last = bit_cnt_w'(frame_bits - 1);

endpackage

//--- project.f
logic/hamming_code_pkg.sv
logic/serial_frame_pkg.sv
logic/hamming_serial_encoder.sv
logic/hamming_syndrome_decoder.sv
logic/hamming_link_top.sv
tests/hamming_link_assert.sv
tests/hamming_link_tb.sv

//--- tests/hamming_link_assert.sv
/* Concurrent checks on strobe timing and decoder flags of the Hamming link.
   Bound onto the encoder and the decoder, with the other block's signals tied off. */
`timescale 1ns/10ps

module hamming_link_assert (
    input logic                                   clk,
    input logic                                   rst_n,
    input logic                                   code_strobe,
    input logic                                   rx_strobe,
    input logic                                   data_strobe,
    input logic [hamming_code_pkg::parity_bits-1:0] syndrome,
    input logic                                   corrected
);

    // codeword strobe is a single-cycle pulse
    a_code_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        code_strobe |=> !code_strobe)
        else $error("code_strobe stayed high for two cycles");

    // decoder latency is two cycles, back to back allowed
    a_data_delay: assert property (@(posedge clk) disable iff (!rst_n)
        rx_strobe |-> ##2 data_strobe)
        else $error("data_strobe missing two cycles after rx_strobe");

    a_data_cause: assert property (@(posedge clk) disable iff (!rst_n)
        data_strobe |-> $past(rx_strobe, 2))
        else $error("data_strobe without an rx_strobe two cycles before");

    // corrected flag tracks a nonzero syndrome
    a_corrected: assert property (@(posedge clk) disable iff (!rst_n)
        data_strobe |-> (corrected == (syndrome != '0)))
        else $error("corrected flag disagrees with syndrome");

endmodule

bind hamming_serial_encoder hamming_link_assert enc_checks (
    .clk(clk), .rst_n(rst_n),
    .code_strobe(code_strobe), .rx_strobe(1'b0), .data_strobe(1'b0),
    .syndrome(3'b000), .corrected(1'b0)
);

bind hamming_syndrome_decoder hamming_link_assert dec_checks (
    .clk(clk), .rst_n(rst_n),
    .code_strobe(1'b0), .rx_strobe(rx_strobe), .data_strobe(data_strobe),
    .syndrome(syndrome), .corrected(corrected)
);

//--- tests/hamming_link_stim.txt
# columns: test name, data nibble, error mask, expected codeword, expected data, expected syndrome
# all values in hex; codeword is {p2, p1, p0, d3, d2, d1, d0}
enc_0 0 00 00 0 0
enc_1 1 00 61 1 0
enc_2 2 00 52 2 0
enc_3 3 00 33 3 0
enc_4 4 00 34 4 0
enc_5 5 00 55 5 0
enc_6 6 00 66 6 0
enc_7 7 00 07 7 0
enc_8 8 00 78 8 0
enc_9 9 00 19 9 0
enc_a a 00 2a a 0
enc_b b 00 4b b 0
enc_c c 00 4c c 0
enc_d d 00 2d d 0
enc_e e 00 1e e 0
enc_f f 00 7f f 0
flip_d0 5 01 55 5 6
flip_d1 a 02 2a a 5
flip_d2 3 04 33 3 3
flip_d3 c 08 4c c 7
flip_p0 9 10 19 9 1
flip_p1 6 20 66 6 2
flip_p2 f 40 7f f 4

//--- tests/hamming_link_tb.sv
/* Testbench for the Hamming(7,4) link: sends frames from the stim file serially, loops
   each codeword back through an error mask and checks encoder and decoder results. */
`timescale 1ns/10ps

module hamming_link_tb;

    localparam int    clk_period = 4;
    localparam int    max_gap    = 3;
    localparam string stim_path  = "tests/hamming_link_stim.txt";

    logic                                     clk;
    logic                                     rst_n;
    logic                                     sin;
    logic                                     sin_strobe;
    logic [hamming_code_pkg::code_bits-1:0]   rx_word;
    logic                                     rx_strobe;
    logic [hamming_code_pkg::code_bits-1:0]   code_word;
    logic                                     code_strobe;
    logic [hamming_code_pkg::data_bits-1:0]   data_out;
    logic [hamming_code_pkg::parity_bits-1:0] syndrome;
    logic                                     corrected;
    logic                                     data_strobe;

    // one entry per stim line
    string                                    test_name[$];
    logic [hamming_code_pkg::data_bits-1:0]   nibble_q[$];
    logic [hamming_code_pkg::code_bits-1:0]   mask_q[$];
    logic [hamming_code_pkg::code_bits-1:0]   exp_code_q[$];
    logic [hamming_code_pkg::data_bits-1:0]   exp_data_q[$];
    logic [hamming_code_pkg::parity_bits-1:0] exp_syn_q[$];

    // words as they left the channel, replayed back to back later
    logic [hamming_code_pkg::code_bits-1:0]   chan_q[$];

    integer seed = 54;
    int     n_tests = 0;
    int     errors = 0;

    hamming_link_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .sin         (sin),
        .sin_strobe  (sin_strobe),
        .code_word   (code_word),
        .code_strobe (code_strobe),
        .rx_word     (rx_word),
        .rx_strobe   (rx_strobe),
        .data_out    (data_out),
        .syndrome    (syndrome),
        .corrected   (corrected),
        .data_strobe (data_strobe)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // drive and sample point, just after the rising edge
    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %0h actual %0h", test, what, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic load_stimulus();
        integer      fd;
        integer      cnt;
        string       line;
        string       name;
        logic [31:0] nib, mask, code, data, syn;
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", stim_path);
            $display("STATUS: FAIL");
            $fatal(1, "no stimulus");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt = $fgets(line, fd);
                // skip blank and comment lines
                if (cnt > 0 && line.len() > 1 && line[0] != "#") begin
                    cnt = $sscanf(line, "%s %h %h %h %h %h", name, nib, mask, code, data, syn);
                    if (cnt == 6) begin
                        test_name.push_back(name);
                        nibble_q.push_back(nib[3:0]);
                        mask_q.push_back(mask[6:0]);
                        exp_code_q.push_back(code[6:0]);
                        exp_data_q.push_back(data[3:0]);
                        exp_syn_q.push_back(syn[2:0]);
                    end
                end
            end
            $fclose(fd);
            n_tests = test_name.size();
        end
    endtask

    // d3 goes first, random idle gaps between bits
    task automatic send_frame(input string name, input logic [3:0] nib);
        int gap;
        int i;
        for (i = serial_frame_pkg::frame_bits - 1; i >= 0; i--) begin
            gap = $unsigned($random(seed)) % (max_gap + 1);
            repeat (gap) wait_cycle();
            sin = nib[i];
            sin_strobe = 1'b1;
            wait_cycle();
            sin_strobe = 1'b0;
            check_value(name, "code_strobe", (i == 0), code_strobe);
        end
    endtask

    task automatic check_result(input string name, input int idx);
        check_value(name, "data_strobe", 1, data_strobe);
        check_value(name, "data_out", exp_data_q[idx], data_out);
        check_value(name, "syndrome", exp_syn_q[idx], syndrome);
        // any single flipped bit must be reported as corrected
        check_value(name, "corrected", (mask_q[idx] != '0), corrected);
    endtask

    // channel with error injection, result due two cycles after the strobe
    task automatic loop_back(input int idx);
        logic [hamming_code_pkg::code_bits-1:0] word;
        word = code_word ^ mask_q[idx];
        chan_q.push_back(word);
        rx_word = word;
        rx_strobe = 1'b1;
        wait_cycle();
        rx_strobe = 1'b0;
        check_value(test_name[idx], "early data_strobe", 0, data_strobe);
        wait_cycle();
        check_result(test_name[idx], idx);
    endtask

    task automatic replay_back_to_back();
        int k;
        for (k = 0; k <= n_tests; k++) begin
            if (k < n_tests) begin
                rx_word = chan_q[k];
                rx_strobe = 1'b1;
            end else begin
                rx_strobe = 1'b0;
            end
            wait_cycle();
            if (k == 0) begin
                check_value("b2b_start", "data_strobe", 0, data_strobe);
            end else begin
                check_result({"b2b_", test_name[k-1]}, k - 1);
            end
        end
        wait_cycle();
        check_value("b2b_end", "data_strobe", 0, data_strobe);
    endtask

    // two bits of a frame, then reset, then a full fresh frame
    task automatic reset_mid_frame(input int idx);
        int          i;
        logic [31:0] rnd;
        for (i = 0; i < 2; i++) begin
            rnd = $random(seed);
            sin = rnd[0];
            sin_strobe = 1'b1;
            wait_cycle();
            sin_strobe = 1'b0;
        end
        rst_n = 1'b0;
        repeat (3) begin
            wait_cycle();
            check_value("reset_mid_frame", "code_strobe", 0, code_strobe);
            check_value("reset_mid_frame", "data_strobe", 0, data_strobe);
        end
        rst_n = 1'b1;
        wait_cycle();
        check_value("reset_release", "code_strobe", 0, code_strobe);
        check_value("reset_release", "data_strobe", 0, data_strobe);
        send_frame("reset_mid_frame", nibble_q[idx]);
        check_value("reset_mid_frame", "code_word", exp_code_q[idx], code_word);
    endtask

    initial begin
        rst_n      = 1'b0;
        sin        = 1'b0;
        sin_strobe = 1'b0;
        rx_word    = '0;
        rx_strobe  = 1'b0;
        load_stimulus();
        check_value("stimulus", "frames loaded", 1, (n_tests > 0));
        repeat (3) begin
            wait_cycle();
            check_value("reset", "code_strobe", 0, code_strobe);
            check_value("reset", "data_strobe", 0, data_strobe);
        end
        rst_n = 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            send_frame(test_name[i], nibble_q[i]);
            check_value(test_name[i], "code_word", exp_code_q[i], code_word);
            loop_back(i);
        end
        replay_back_to_back();
        reset_mid_frame(n_tests / 2);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // limit scales with the number of frames in the run
    initial begin
        wait (n_tests > 0);
        #((2 * n_tests + 4) * (serial_frame_pkg::frame_bits * (max_gap + 1) + 8) * clk_period);
        $display("watchdog expired before all frames were checked");
        $display("STATUS: FAIL");
        $fatal(1, "simulation timed out");
    end

endmodule
